// File: logic/branch_target_buffer.sv
`timescale 1ns/100ps

module branch_target_buffer #(
    parameter int btb_entries = 16
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [31:0]            lookup_pc,
    output fetch_pkg::btb_pred_t   pred,
    input  fetch_pkg::btb_update_t upd
);
    import fetch_pkg::*;

    localparam int idx_w = $clog2(btb_entries);
    localparam int tag_w = addr_w - 3 - idx_w;

    typedef struct packed {
        logic [tag_w-1:0]  tag;
        logic              slot;
        logic              taken;
        logic [addr_w-1:0] target;
    } btb_entry_t;

    btb_entry_t             entries [btb_entries];
    logic [btb_entries-1:0] valid_q;
    logic [idx_w-1:0]       rd_idx;
    logic [idx_w-1:0]       wr_idx;
    btb_entry_t             rd_entry;
    btb_entry_t             wr_entry;
    logic                   tag_match;
    logic                   hit;

    // one entry per instruction pair
    assign rd_idx   = lookup_pc[3 +: idx_w];
    assign wr_idx   = upd.pc[3 +: idx_w];
    assign rd_entry = entries[rd_idx];

    assign tag_match = rd_entry.tag == lookup_pc[addr_w-1 -: tag_w];

    // a branch in slot 0 is skipped when fetch starts at the upper slot
    assign hit = valid_q[rd_idx] && tag_match && (rd_entry.slot || !lookup_pc[2]);

    always_comb begin
        pred.taken  = hit && rd_entry.taken;
        pred.slot   = rd_entry.slot;
        pred.target = rd_entry.target;
    end

    always_comb begin
        wr_entry.tag    = upd.pc[addr_w-1 -: tag_w];
        wr_entry.slot   = upd.pc[2];
        wr_entry.taken  = upd.taken;
        wr_entry.target = upd.target;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (upd.valid) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // entry payload, guarded by valid_q
    always_ff @(posedge clk) begin
        if (upd.valid) begin
            entries[wr_idx] <= wr_entry;
        end
    end

endmodule

// File: logic/fetch_pkg.sv
package fetch_pkg;

    // fetch starts here after reset
    localparam logic [31:0] pc_reset = 32'h1c00_0000;

    localparam int addr_w      = 32;
    localparam int axil_data_w = 64;

    // one redirect request from a later stage
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] target;
    } redirect_t;

    // training from execute
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] pc;
        logic [addr_w-1:0] target;
        logic              taken;
    } btb_update_t;

    // lookup result, slot tells which half of the pair holds the branch
    typedef struct packed {
        logic              taken;
        logic              slot;
        logic [addr_w-1:0] target;
    } btb_pred_t;

    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic              upper_only;
        logic              pred_taken;
        logic              pred_slot;
        logic [addr_w-1:0] pred_target;
        logic              epoch;
    } fetch_req_t;

    // slot 0 is the lower word of the pair
    typedef struct packed {
        logic [addr_w-1:0]      pc;
        logic [1:0]             slot_valid;
        logic [1:0][31:0]       insn;
        logic                   pred_taken;
        logic [addr_w-1:0]      pred_target;
        logic                   epoch;
    } fetch_pkt_t;

    typedef struct packed {
        logic [addr_w-1:0] araddr;
        logic [2:0]        arprot;
    } axil_ar_t;

    typedef struct packed {
        logic [axil_data_w-1:0] rdata;
        logic [1:0]             rresp;
    } axil_r_t;

endpackage

// File: logic/fetch_queue.sv
`timescale 1ns/100ps

module fetch_queue #(
    parameter int queue_depth = 4
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  pkt_valid,
    input  fetch_pkg::fetch_pkt_t pkt,
    input  logic                  flush,
    input  logic                  cur_epoch,
    output logic                  drop,
    output logic                  deq,
    output logic                  out_valid,
    input  logic                  out_ready,
    output fetch_pkg::fetch_pkt_t out_pkt
);
    import fetch_pkg::*;

    localparam int ptr_w = $clog2(queue_depth);

    fetch_pkt_t       mem [queue_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             accept_in;
    logic             out_free;
    logic             load_mem;
    logic             bypass;
    logic             write_mem;

    // space is guaranteed by credits upstream, no full check
    assign accept_in = pkt_valid && !flush && (pkt.epoch == cur_epoch);
    assign drop      = pkt_valid && !accept_in;
    assign deq       = out_valid && out_ready;

    assign out_free  = !out_valid || out_ready;
    assign load_mem  = out_free && (count != '0);
    // empty storage, straight into the output register
    assign bypass    = out_free && (count == '0) && accept_in;
    assign write_mem = accept_in && !bypass;

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            wr_ptr    <= wr_ptr + ptr_w'(write_mem);
            rd_ptr    <= rd_ptr + ptr_w'(load_mem);
            count     <= count + (ptr_w + 1)'(write_mem) - (ptr_w + 1)'(load_mem);
            out_valid <= load_mem || bypass || (out_valid && !out_ready);
        end
    end

    always_ff @(posedge clk) begin
        if (write_mem) begin
            mem[wr_ptr] <= pkt;
        end
        if (load_mem) begin
            out_pkt <= mem[rd_ptr];
        end else if (bypass) begin
            out_pkt <= pkt;
        end
    end

endmodule

// File: logic/fetch_top.sv
`timescale 1ns/100ps

module fetch_top #(
    parameter int btb_entries = 16,
    parameter int queue_depth = 4
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  fetch_pkg::redirect_t   redir_wb,
    input  fetch_pkg::redirect_t   redir_ex,
    input  fetch_pkg::redirect_t   redir_id,
    input  fetch_pkg::redirect_t   redir_priv,
    input  fetch_pkg::btb_update_t btb_upd,
    output logic                   arvalid,
    input  logic                   arready,
    output fetch_pkg::axil_ar_t    ar,
    input  logic                   rvalid,
    output logic                   rready,
    input  fetch_pkg::axil_r_t     r,
    output logic                   out_valid,
    input  logic                   out_ready,
    output fetch_pkg::fetch_pkt_t  out_pkt
);
    import fetch_pkg::*;

    btb_pred_t         pred;
    logic [addr_w-1:0] lookup_pc;
    logic              req_valid;
    logic              req_ready;
    fetch_req_t        req;
    logic              pkt_valid;
    fetch_pkt_t        pkt;
    logic              flush;
    logic              cur_epoch;
    logic              deq;
    logic              drop;

    pc_gen #(.queue_depth(queue_depth)) u_pc_gen (
        .clk(clk), .rstn(rstn),
        .redir_wb(redir_wb), .redir_ex(redir_ex),
        .redir_id(redir_id), .redir_priv(redir_priv),
        .pred(pred), .lookup_pc(lookup_pc),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .deq(deq), .drop(drop), .flush(flush), .cur_epoch(cur_epoch)
    );

    branch_target_buffer #(.btb_entries(btb_entries)) u_btb (
        .clk(clk), .rstn(rstn),
        .lookup_pc(lookup_pc), .pred(pred), .upd(btb_upd)
    );

    imem_axil_reader u_reader (
        .clk(clk), .rstn(rstn),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .arvalid(arvalid), .arready(arready), .ar(ar),
        .rvalid(rvalid), .rready(rready), .r(r),
        .pkt_valid(pkt_valid), .pkt(pkt)
    );

    fetch_queue #(.queue_depth(queue_depth)) u_queue (
        .clk(clk), .rstn(rstn),
        .pkt_valid(pkt_valid), .pkt(pkt),
        .flush(flush), .cur_epoch(cur_epoch),
        .drop(drop), .deq(deq),
        .out_valid(out_valid), .out_ready(out_ready), .out_pkt(out_pkt)
    );

endmodule

// File: logic/imem_axil_reader.sv
`timescale 1ns/100ps

module imem_axil_reader (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  req_valid,
    input  fetch_pkg::fetch_req_t req,
    output logic                  req_ready,
    output logic                  arvalid,
    input  logic                  arready,
    output fetch_pkg::axil_ar_t   ar,
    input  logic                  rvalid,
    output logic                  rready,
    input  fetch_pkg::axil_r_t    r,
    output logic                  pkt_valid,
    output fetch_pkg::fetch_pkt_t pkt
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data
    } state_t;

    state_t     state;
    fetch_req_t req_q;

    // one read outstanding at most
    assign req_ready = state == st_idle;
    assign arvalid   = state == st_addr;
    assign rready    = state == st_data;
    assign pkt_valid = rready && rvalid;

    // instruction fetch, unprivileged
    assign ar.araddr = {req_q.pc[addr_w-1:3], 3'b000};
    assign ar.arprot = 3'b100;

    always_comb begin
        pkt.pc          = req_q.pc;
        pkt.insn[0]     = r.rdata[31:0];
        pkt.insn[1]     = r.rdata[63:32];
        pkt.slot_valid[0] = !req_q.upper_only;
        // taken branch in slot 0 kills slot 1
        pkt.slot_valid[1] = !(req_q.pred_taken && !req_q.pred_slot);
        pkt.pred_taken  = req_q.pred_taken;
        pkt.pred_target = req_q.pred_target;
        pkt.epoch       = req_q.epoch;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (req_valid) begin
                        state <= st_addr;
                    end
                end
                st_addr: begin
                    if (arready) begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    // response code ignored
                    if (rvalid) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
    end

endmodule

// File: logic/pc_gen.sv
`timescale 1ns/100ps

module pc_gen #(
    parameter int queue_depth = 4
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  fetch_pkg::redirect_t  redir_wb,
    input  fetch_pkg::redirect_t  redir_ex,
    input  fetch_pkg::redirect_t  redir_id,
    input  fetch_pkg::redirect_t  redir_priv,
    input  fetch_pkg::btb_pred_t  pred,
    output logic [31:0]           lookup_pc,
    output logic                  req_valid,
    output fetch_pkg::fetch_req_t req,
    input  logic                  req_ready,
    input  logic                  deq,
    input  logic                  drop,
    output logic                  flush,
    output logic                  cur_epoch
);
    import fetch_pkg::*;

    localparam int credit_w = $clog2(queue_depth) + 1;
    localparam logic [credit_w-1:0] credit_full = credit_w'(queue_depth);

    logic [addr_w-1:0]   pc;
    logic [addr_w-1:0]   pc_aligned;
    logic [addr_w-1:0]   pc_next;
    logic                epoch;
    logic                active;
    logic [credit_w-1:0] credits;
    logic                accept;
    redirect_t           redir_sel;

    // fixed priority, writeback first
    always_comb begin
        if (redir_wb.valid) begin
            redir_sel = redir_wb;
        end else if (redir_ex.valid) begin
            redir_sel = redir_ex;
        end else if (redir_id.valid) begin
            redir_sel = redir_id;
        end else begin
            redir_sel = redir_priv;
        end
    end

    assign flush     = redir_sel.valid;
    assign cur_epoch = epoch;
    assign lookup_pc = pc;

    // an upper-only fetch falls back to alignment here as well
    assign pc_aligned = {pc[addr_w-1:3], 3'b000};
    assign pc_next    = pred.taken ? pred.target : pc_aligned + 32'd8;

    // nothing new goes out in a flush cycle, it would carry the old epoch
    assign req_valid = active && (credits != '0) && !flush;
    assign accept    = req_valid && req_ready;

    always_comb begin
        req.pc          = pc;
        req.upper_only  = pc[2];
        req.pred_taken  = pred.taken;
        req.pred_slot   = pred.slot;
        req.pred_target = pred.target;
        req.epoch       = epoch;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc      <= pc_reset;
            epoch   <= 1'b0;
            active  <= 1'b0;
            credits <= credit_full;
        end else begin
            active <= 1'b1;
            if (flush) begin
                pc    <= redir_sel.target;
                epoch <= ~epoch;
                // a read still out will come back stale and return its credit on drop
                credits <= credit_full - credit_w'(!req_ready) + credit_w'(drop);
            end else begin
                if (accept) begin
                    pc <= pc_next;
                end
                credits <= credits - credit_w'(accept) + credit_w'(deq) + credit_w'(drop);
            end
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module fetch_tb -o fetch_sim
output=$(./obj_dir/fetch_sim)
echo "$output"
if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

// File: verification/axil_imem_model.sv
`timescale 1ns/100ps

module axil_imem_model (
    input  logic                clk,
    input  logic                rstn,
    input  logic                arvalid,
    output logic                arready,
    input  fetch_pkg::axil_ar_t ar,
    output logic                rvalid,
    input  logic                rready,
    output fetch_pkg::axil_r_t  r
);
    import fetch_pkg::*;

    logic [addr_w-1:0] addr_q;
    logic              busy;
    logic [1:0]        ar_delay;
    logic [1:0]        r_delay;

    // address side, ready after a random wait of 0 to 3 cycles
    always_ff @(posedge clk) begin
        if (!rstn) begin
            arready  <= 1'b0;
            busy     <= 1'b0;
            addr_q   <= '0;
            ar_delay <= 2'($urandom);
        end else if (arvalid && arready) begin
            arready  <= 1'b0;
            busy     <= 1'b1;
            addr_q   <= ar.araddr;
            ar_delay <= 2'($urandom);
        end else if (arvalid && !busy) begin
            if (ar_delay == 2'd0) begin
                arready <= 1'b1;
            end else begin
                ar_delay <= ar_delay - 2'd1;
            end
        end else if (rvalid && rready) begin
            busy <= 1'b0;
        end
    end

    // lower word holds the address, upper word the address + 4
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rvalid  <= 1'b0;
            r       <= '0;
            r_delay <= 2'($urandom);
        end else if (rvalid && rready) begin
            rvalid  <= 1'b0;
            r_delay <= 2'($urandom);
        end else if (busy && !rvalid) begin
            if (r_delay == 2'd0) begin
                rvalid  <= 1'b1;
                r.rdata <= {addr_q + 32'd4, addr_q};
                r.rresp <= 2'b00;
            end else begin
                r_delay <= r_delay - 2'd1;
            end
        end
    end

endmodule

// File: verification/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;
    import fetch_pkg::*;

    typedef struct {
        string       name;
        logic [3:0]  mask;        // wb, ex, id, priv
        logic [31:0] target;
        logic [31:0] upd_pc;      // zero means no btb training
        logic [31:0] upd_target;
        int          in_flight;
        int          stall;
        logic [7:0]  ready_pat;
        int          count;
        logic [31:0] exp_pc;
        logic [1:0]  exp_slots;
    } test_row_t;

    localparam int num_rows = 10;

    logic        clk = 1'b0;
    logic        rstn;
    redirect_t   redir_wb;
    redirect_t   redir_ex;
    redirect_t   redir_id;
    redirect_t   redir_priv;
    btb_update_t btb_upd;
    logic        arvalid;
    logic        arready;
    axil_ar_t    ar;
    logic        rvalid;
    logic        rready;
    axil_r_t     r;
    logic        out_valid;
    logic        out_ready;
    fetch_pkt_t  out_pkt;

    test_row_t   rows [num_rows];
    logic [31:0] trained_pc [$];
    logic [31:0] trained_target [$];
    int          check_count = 0;
    int          error_count = 0;
    int          limit_cycles = 0;

    always #50 clk = ~clk;

    fetch_top #(.btb_entries(16), .queue_depth(4)) uut (.*);

    axil_imem_model mem_model (.*);

    task automatic load_table();
        rows[0] = '{"reset_seq", 4'b0000, 'h0, 'h0, 'h0, 0, 0, 8'hff, 6, 'h1c000000, 2'b11};
        rows[1] = '{"btb_slot0", 4'b1000, 'h1c002000, 'h1c002000, 'h1c003000, 0, 0, 8'hff, 4,
                    'h1c002000, 2'b01};
        rows[2] = '{"btb_slot1", 4'b1000, 'h1c00400c, 'h1c00400c, 'h1c005004, 0, 0, 8'hff, 4,
                    'h1c00400c, 2'b10};
        // source k redirects to target + k * 0x100
        rows[3] = '{"prio_ex", 4'b0111, 'h1c006000, 'h0, 'h0, 0, 0, 8'hff, 3, 'h1c006100, 2'b11};
        rows[4] = '{"prio_id", 4'b0011, 'h1c007000, 'h0, 'h0, 0, 0, 8'hff, 3, 'h1c007200, 2'b11};
        rows[5] = '{"prio_priv", 4'b0001, 'h1c008000, 'h0, 'h0, 0, 0, 8'hff, 3, 'h1c008300, 2'b11};
        rows[6] = '{"prio_wb", 4'b1111, 'h1c009000, 'h0, 'h0, 0, 0, 8'hff, 3, 'h1c009000, 2'b11};
        rows[7] = '{"upper_only", 4'b1000, 'h1c00a004, 'h0, 'h0, 0, 0, 8'hff, 3, 'h1c00a004, 2'b10};
        rows[8] = '{"backpressure", 4'b1000, 'h1c00b000, 'h0, 'h0, 0, 40, 8'ha6, 12,
                    'h1c00b000, 2'b11};
        rows[9] = '{"stale_read", 4'b1000, 'h1c00c000, 'h0, 'h0, 1, 0, 8'hff, 4, 'h1c00c000, 2'b11};
    endtask

    task automatic check_value(input string test, input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        assert (act === exp) else begin
            error_count++;
            $display("CHECK FAILED %s %s expected %h actual %h", test, what, exp, act);
        end
    endtask

    // every read address is pair aligned and marked as an instruction access
    always @(negedge clk) begin
        if (rstn && arvalid && arready) begin
            check_value("axi_ar", "araddr[2:0]", 32'd0, 32'(ar.araddr[2:0]));
            check_value("axi_ar", "arprot[2]", 32'd1, 32'(ar.arprot[2]));
        end
    end

    // a branch in slot 0 does not apply when the fetch starts at the upper slot
    function automatic logic find_branch(input logic [31:0] pc, output logic slot,
                                         output logic [31:0] target);
        find_branch = 1'b0;
        slot = 1'b0;
        target = '0;
        for (int i = 0; i < trained_pc.size(); i++) begin
            if (trained_pc[i][31:3] == pc[31:3] && (trained_pc[i][2] || !pc[2])) begin
                find_branch = 1'b1;
                slot = trained_pc[i][2];
                target = trained_target[i];
            end
        end
    endfunction

    task automatic train_btb(input logic [31:0] pc, input logic [31:0] target);
        @(posedge clk);
        btb_upd <= '{1'b1, pc, target, 1'b1};
        @(posedge clk);
        btb_upd <= '0;
        trained_pc.push_back(pc);
        trained_target.push_back(target);
    endtask

    // free some credits so that a read is issued, then stop at its address phase
    task automatic wait_read_in_flight();
        @(posedge clk);
        out_ready <= 1'b1;
        @(negedge clk);
        while (!arvalid) begin
            @(negedge clk);
        end
    endtask

    task automatic apply_redirect(input string test, input logic [3:0] mask,
                                  input logic [31:0] target);
        @(posedge clk);
        out_ready  <= 1'b0;
        redir_wb   <= '{mask[3], target};
        redir_ex   <= '{mask[2], target + 32'h100};
        redir_id   <= '{mask[1], target + 32'h200};
        redir_priv <= '{mask[0], target + 32'h300};
        @(posedge clk);
        redir_wb   <= '0;
        redir_ex   <= '0;
        redir_id   <= '0;
        redir_priv <= '0;
        // queue must be empty right after the flush edge
        @(negedge clk);
        check_value(test, "out_valid after redirect", 32'd0, 32'(out_valid));
    endtask

    task automatic run_row(input test_row_t row);
        logic [31:0] pc;
        logic [31:0] base;
        logic [31:0] tgt;
        logic [1:0]  slots;
        logic [2:0]  pat_idx;
        logic        taken;
        logic        br_slot;
        string       label;
        int          k;
        if (row.upd_pc != 32'd0) begin
            train_btb(row.upd_pc, row.upd_target);
        end
        if (row.in_flight != 0) begin
            wait_read_in_flight();
        end
        if (row.mask != 4'b0000) begin
            apply_redirect(row.name, row.mask, row.target);
        end
        repeat (row.stall) @(posedge clk);
        pc = row.exp_pc;
        pat_idx = 3'd0;
        k = 0;
        while (k < row.count) begin
            @(posedge clk);
            out_ready <= row.ready_pat[pat_idx];
            pat_idx = pat_idx + 3'd1;
            @(negedge clk);
            if (out_valid && out_ready) begin
                label = $sformatf("%s pkt %0d", row.name, k);
                taken = find_branch(pc, br_slot, tgt);
                base = {pc[31:3], 3'b000};
                // slot 1 dies behind a taken branch in slot 0
                slots = (k == 0) ? row.exp_slots : {!(taken && !br_slot), !pc[2]};
                check_value(label, "pc", pc, out_pkt.pc);
                check_value(label, "slot_valid", 32'(slots), 32'(out_pkt.slot_valid));
                check_value(label, "insn0", base, out_pkt.insn[0]);
                check_value(label, "insn1", base + 32'd4, out_pkt.insn[1]);
                check_value(label, "pred_taken", 32'(taken), 32'(out_pkt.pred_taken));
                if (taken) begin
                    check_value(label, "pred_target", tgt, out_pkt.pred_target);
                end
                pc = taken ? tgt : base + 32'd8;
                k++;
            end
        end
        @(posedge clk);
        out_ready <= 1'b0;
    endtask

    initial begin
        void'($urandom(25));
        rstn       = 1'b0;
        redir_wb   = '0;
        redir_ex   = '0;
        redir_id   = '0;
        redir_priv = '0;
        btb_upd    = '0;
        out_ready  = 1'b0;
        load_table();
        for (int i = 0; i < num_rows; i++) begin
            limit_cycles += rows[i].count * 20 + rows[i].stall;
        end
        repeat (7) @(posedge clk);
        @(negedge clk);
        check_value("reset", "arvalid", 32'd0, 32'(arvalid));
        check_value("reset", "rready", 32'd0, 32'(rready));
        check_value("reset", "out_valid", 32'd0, 32'(out_valid));
        @(posedge clk);
        rstn <= 1'b1;
        for (int i = 0; i < num_rows; i++) begin
            run_row(rows[i]);
        end
        $display("checks %0d errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog, reset and flush overhead on top of the table length
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles + 20) @(posedge clk);
        $display("timeout, the tests did not finish within %0d cycles", limit_cycles + 20);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: vlog.f
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/branch_target_buffer.sv
logic/imem_axil_reader.sv
logic/fetch_queue.sv
logic/fetch_top.sv
verification/axil_imem_model.sv
verification/fetch_tb.sv
